//--- logic/mem_pkg.sv
package mem_pkg;

  // **************************************************
  // Bus and memory geometry
  // **************************************************

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int ADDR_LSB  = $clog2(STRB_W);

  localparam int MEM_WORDS = 1024;
  localparam int MEM_BYTES = MEM_WORDS * STRB_W;
  localparam int WORD_AW   = $clog2(MEM_WORDS);

  // **************************************************
  // Latency generation
  // **************************************************

  // Low LFSR bits added on top of the minimum wait
  localparam int LAT_BITS  = 4;
  localparam int LAT_MIN   = 2;
  // Countdown must hold LAT_MIN + 2**LAT_BITS - 1
  localparam int LAT_W     = $clog2(LAT_MIN + (1 << LAT_BITS));

  localparam logic [7:0] LFSR_SEED = 8'h95;
  localparam logic [7:0] LFSR_TAPS = 8'hB8;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // **************************************************
  // Channel payloads
  // **************************************************

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axi_r_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

//--- logic/latency_lfsr.sv
module latency_lfsr (
  input  logic       clk,
  input  logic       rstn,
  output logic [7:0] lfsr_val
);
  import mem_pkg::*;

  logic [7:0] state;
  logic [7:0] state_nxt;

  // Galois form with feedback from the bit shifted out
  always_comb begin
    if (state[0]) begin
      state_nxt = (state >> 1) ^ LFSR_TAPS;
    end else begin
      state_nxt = state >> 1;
    end
  end

  // Free-running once reset is released
  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= LFSR_SEED;
    end else begin
      state <= state_nxt;
    end
  end

  assign lfsr_val = state;

endmodule

//--- logic/sram_array.sv
module sram_array (
  input  logic                        clk,
  input  logic                        we,
  input  logic [mem_pkg::WORD_AW-1:0] wr_addr,
  input  logic [mem_pkg::DATA_W-1:0]  wr_data,
  input  logic [mem_pkg::STRB_W-1:0]  wr_strb,
  input  logic [mem_pkg::WORD_AW-1:0] rd_addr,
  output logic [mem_pkg::DATA_W-1:0]  rd_data
);
  import mem_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];

  // **************************************************
  // Byte-lane write
  // **************************************************

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // **************************************************
  // Asynchronous read
  // **************************************************

  // Returns the word as it stands before any write on this edge
  assign rd_data = mem[rd_addr];

endmodule

//--- logic/sram_rd_ctrl.sv
module sram_rd_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic [7:0]                  lfsr_val,
  input  mem_pkg::axi_ar_t            ar,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  output mem_pkg::axi_r_t             r,
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [mem_pkg::WORD_AW-1:0] rd_addr,
  input  logic [mem_pkg::DATA_W-1:0]  rd_data
);
  import mem_pkg::*;

  axi_ar_t          ar_q;
  logic [LAT_W-1:0] cnt;
  logic             ar_hs;
  logic             fire;
  logic             in_range;

  assign ar_hs    = ar_valid && ar_ready;
  // Count parks at 1 until the previous beat has left
  assign fire     = (cnt == LAT_W'(1)) && !r_valid;
  assign in_range = ar_q.addr < ADDR_W'(MEM_BYTES);
  assign rd_addr  = ar_q.addr[ADDR_LSB +: WORD_AW];

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      ar_q <= ar;
    end
  end

  // **************************************************
  // Handshake and latency countdown
  // **************************************************

  always_ff @(posedge clk) begin
    if (rstn) begin
      ar_ready <= 1'b1;
      r_valid  <= 1'b0;
      cnt      <= '0;
    end else begin
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
      if (ar_hs) begin
        ar_ready <= 1'b0;
        cnt      <= LAT_W'(LAT_MIN) + LAT_W'(lfsr_val[LAT_BITS-1:0]);
      end else if (fire) begin
        ar_ready <= 1'b1;
        r_valid  <= 1'b1;
        cnt      <= '0;
      end else if (cnt > LAT_W'(1)) begin
        cnt <= cnt - LAT_W'(1);
      end
    end
  end

  // Out-of-range reads return zero with an error
  always_ff @(posedge clk) begin
    if (fire) begin
      r.data <= in_range ? rd_data : '0;
      r.resp <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // **************************************************
  // Checks
  // **************************************************

  a_r_stable: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !r_ready |=> r_valid && $stable(r));

  // No count running means the engine must be able to make progress
  a_idle_live: assert property (@(posedge clk) disable iff (rstn)
    cnt == '0 |-> ar_ready || r_valid);

endmodule

//--- logic/sram_wr_ctrl.sv
module sram_wr_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic [7:0]                  lfsr_val,
  input  mem_pkg::axi_aw_t            aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  mem_pkg::axi_w_t             w,
  input  logic                        w_valid,
  output logic                        w_ready,
  output mem_pkg::axi_b_t             b,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic                        we,
  output logic [mem_pkg::WORD_AW-1:0] wr_addr,
  output logic [mem_pkg::DATA_W-1:0]  wr_data,
  output logic [mem_pkg::STRB_W-1:0]  wr_strb
);
  import mem_pkg::*;

  axi_aw_t          aw_q;
  axi_w_t           w_q;
  logic [LAT_W-1:0] cnt;
  logic             aw_hs;
  logic             w_hs;
  logic             start;
  logic             fire;
  logic             in_range;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;

  // Second half arrives, or both land together
  assign start = (aw_hs && (w_hs || !w_ready)) || (w_hs && !aw_ready);

  // Commit waits for the previous response to be taken
  assign fire     = (cnt == LAT_W'(1)) && !b_valid;
  assign in_range = aw_q.addr < ADDR_W'(MEM_BYTES);

  // **************************************************
  // Request holding registers
  // **************************************************

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_q <= aw;
    end
  end

  always_ff @(posedge clk) begin
    if (w_hs) begin
      w_q <= w;
    end
  end

  // **************************************************
  // Handshake and latency countdown
  // **************************************************

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_ready <= 1'b1;
      w_ready  <= 1'b1;
      b_valid  <= 1'b0;
      cnt      <= '0;
    end else begin
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
      if (aw_hs) begin
        aw_ready <= 1'b0;
      end
      if (w_hs) begin
        w_ready <= 1'b0;
      end
      if (start) begin
        cnt <= LAT_W'(LAT_MIN) + LAT_W'(lfsr_val[LAT_BITS-1:0]);
      end else if (fire) begin
        aw_ready <= 1'b1;
        w_ready  <= 1'b1;
        b_valid  <= 1'b1;
        cnt      <= '0;
      end else if (cnt > LAT_W'(1)) begin
        cnt <= cnt - LAT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      b.resp <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // **************************************************
  // Array write port
  // **************************************************

  // Out-of-range writes still answer but never touch the array
  assign we      = fire && in_range;
  assign wr_addr = aw_q.addr[ADDR_LSB +: WORD_AW];
  assign wr_data = w_q.data;
  assign wr_strb = w_q.strb;

  a_b_stable: assert property (@(posedge clk) disable iff (rstn)
    b_valid && !b_ready |=> b_valid && $stable(b));

  a_we_with_b: assert property (@(posedge clk) disable iff (rstn)
    we |=> $rose(b_valid));

endmodule

//--- logic/axi_sram.sv
module axi_sram (
  input  logic              clk,
  input  logic              rstn,

  input  mem_pkg::axi_ar_t  ar,
  input  logic              ar_valid,
  output logic              ar_ready,

  output mem_pkg::axi_r_t   r,
  output logic              r_valid,
  input  logic              r_ready,

  input  mem_pkg::axi_aw_t  aw,
  input  logic              aw_valid,
  output logic              aw_ready,

  input  mem_pkg::axi_w_t   w,
  input  logic              w_valid,
  output logic              w_ready,

  output mem_pkg::axi_b_t   b,
  output logic              b_valid,
  input  logic              b_ready
);
  import mem_pkg::*;

  logic [7:0]         lfsr_val;
  logic [WORD_AW-1:0] rd_addr;
  logic [DATA_W-1:0]  rd_data;
  logic               we;
  logic [WORD_AW-1:0] wr_addr;
  logic [DATA_W-1:0]  wr_data;
  logic [STRB_W-1:0]  wr_strb;

  // One random source shared by both channels
  latency_lfsr latency_lfsr_inst (
    .clk      (clk),
    .rstn     (rstn),
    .lfsr_val (lfsr_val)
  );

  sram_rd_ctrl sram_rd_ctrl_inst (
    .clk      (clk),
    .rstn     (rstn),
    .lfsr_val (lfsr_val),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  sram_wr_ctrl sram_wr_ctrl_inst (
    .clk      (clk),
    .rstn     (rstn),
    .lfsr_val (lfsr_val),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .we       (we),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb)
  );

  sram_array sram_array_inst (
    .clk     (clk),
    .we      (we),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_strb (wr_strb),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- tb/tb_axi_sram.sv
module tb_axi_sram;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int N_OPS      = 80;
  localparam int MAX_STALL  = 16;
  localparam int TIMEOUT_NS = N_OPS * (LAT_MIN + 16 + MAX_STALL) * 10 + 2000;

  logic     clk;
  logic     rstn;
  axi_ar_t  ar;
  logic     ar_valid, ar_ready;
  axi_r_t   r;
  logic     r_valid, r_ready;
  axi_aw_t  aw;
  logic     aw_valid, aw_ready;
  axi_w_t   w;
  logic     w_valid, w_ready;
  axi_b_t   b;
  logic     b_valid, b_ready;

  logic [DATA_W-1:0] shadow [MEM_WORDS];
  logic [DATA_W-1:0] exp_rdata [64];
  logic [1:0]        exp_rresp [64];
  logic [1:0]        exp_bresp [64];
  int r_issued, r_done, b_issued, b_done;
  int errors, last_errors, test_num, failed_tests;
  logic [31:0] lfsr;

  axi_sram axi_sram_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // **************************************************
  // Checks
  // **************************************************

  a_reset_state: assert property (@(posedge clk) $fell(rstn) |->
    ar_ready && aw_ready && w_ready && !r_valid && !b_valid)
    else begin
      $display("Mismatch reset ar_ready/aw_ready/w_ready exp 1/1/1 got %h/%h/%h",
        $sampled(ar_ready), $sampled(aw_ready), $sampled(w_ready));
      $display("Mismatch reset r_valid/b_valid exp 0/0 got %h/%h",
        $sampled(r_valid), $sampled(b_valid));
      errors++;
    end

  a_r_value: assert property (@(posedge clk) disable iff (rstn) r_valid && r_ready |->
    r.data == exp_rdata[r_done[5:0]] && r.resp == exp_rresp[r_done[5:0]])
    else begin
      $display("Mismatch r.data/r.resp exp %h/%h got %h/%h",
        $sampled(exp_rdata[r_done[5:0]]), $sampled(exp_rresp[r_done[5:0]]),
        $sampled(r.data), $sampled(r.resp));
      errors++;
    end

  a_b_value: assert property (@(posedge clk) disable iff (rstn) b_valid && b_ready |->
    b.resp == exp_bresp[b_done[5:0]])
    else begin
      $display("Mismatch b.resp exp %h got %h",
        $sampled(exp_bresp[b_done[5:0]]), $sampled(b.resp));
      errors++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      $display("R channel changed or dropped r_valid while stalled");
      errors++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (rstn)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
      $display("B channel changed or dropped b_valid while stalled");
      errors++;
    end

  always @(posedge clk) begin
    if (!rstn && r_valid && r_ready) r_done <= r_done + 1;
    if (!rstn && b_valid && b_ready) b_done <= b_done + 1;
  end

  // **************************************************
  // Stimulus helpers
  // **************************************************

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_addr();
    logic [WORD_AW-1:0] idx;
    idx = WORD_AW'(rand_bits(WORD_AW));
    return ADDR_W'(idx) << ADDR_LSB;
  endfunction

  task automatic send_ar(input logic [ADDR_W-1:0] addr);
    exp_rdata[r_issued[5:0]] = (addr < MEM_BYTES) ? shadow[addr[ADDR_LSB +: WORD_AW]] : '0;
    exp_rresp[r_issued[5:0]] = (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
    r_issued++;
    ar.addr  = addr;
    ar_valid = 1'b1;
    while (!ar_ready) @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  // Mode 0 sends both on one edge, 1 sends W first, 2 sends AW first
  task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input int mode);
    if (addr < MEM_BYTES) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (strb[i]) shadow[addr[ADDR_LSB +: WORD_AW]][8*i +: 8] = data[8*i +: 8];
      end
    end
    exp_bresp[b_issued[5:0]] = (addr < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
    b_issued++;
    aw.addr = addr;
    w.data  = data;
    w.strb  = strb;
    if (mode == 0) begin
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      while (!(aw_ready && w_ready)) @(negedge clk);
      @(negedge clk);
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end else begin
      w_valid  = (mode == 1);
      aw_valid = (mode == 2);
      while (!(mode == 1 ? w_ready : aw_ready)) @(negedge clk);
      @(negedge clk);
      w_valid  = (mode == 2);
      aw_valid = (mode == 1);
      while (!(mode == 1 ? aw_ready : w_ready)) @(negedge clk);
      @(negedge clk);
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end
  endtask

  task automatic wait_done();
    while (r_done < r_issued || b_done < b_issued) @(negedge clk);
  endtask

  task automatic write_then_read(input logic [ADDR_W-1:0] addr, input logic [STRB_W-1:0] strb,
                                 input int mode);
    send_write(addr, rand_bits(32), strb, mode);
    wait_done();
    send_ar(addr);
    wait_done();
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (errors == last_errors) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, errors - last_errors);
      failed_tests++;
    end
    last_errors = errors;
  endtask

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin
    logic [ADDR_W-1:0] a1;
    logic [ADDR_W-1:0] a2;
    rstn = 1'b1;
    ar = '0;
    ar_valid = 1'b0;
    r_ready = 1'b1;
    aw = '0;
    aw_valid = 1'b0;
    w = '0;
    w_valid = 1'b0;
    b_ready = 1'b1;
    lfsr = 32'hbdde_7ef7;
    r_issued = 0;
    b_issued = 0;
    {errors, last_errors, test_num, failed_tests} = '0;
    repeat (2) @(negedge clk);
    rstn = 1'b0;
    @(negedge clk);
    finish_test("reset state");

    for (int i = 0; i < 8; i++) write_then_read(rand_addr(), 4'hf, 0);
    finish_test("full write and read back");

    for (int i = 0; i < 4; i++) begin
      a1 = rand_addr();
      write_then_read(a1, 4'hf, 0);
      write_then_read(a1, STRB_W'(rand_bits(STRB_W)), 2);
    end
    finish_test("partial strobe");

    for (int i = 0; i < 4; i++) write_then_read(rand_addr(), 4'hf, 1);
    for (int i = 0; i < 4; i++) write_then_read(rand_addr(), 4'hf, 0);
    finish_test("W before AW and same edge");

    for (int i = 0; i < 2; i++) begin
      a1 = rand_addr();
      a2 = rand_addr();
      b_ready = 1'b0;
      send_write(a1, rand_bits(32), 4'hf, 0);
      while (!b_valid) @(negedge clk);
      send_write(a2, rand_bits(32), 4'hf, 0);
      repeat (rand_bits(4) + 1) @(negedge clk);
      b_ready = 1'b1;
      wait_done();
      r_ready = 1'b0;
      send_ar(a1);
      while (!r_valid) @(negedge clk);
      send_ar(a2);
      repeat (rand_bits(4) + 1) @(negedge clk);
      r_ready = 1'b1;
      wait_done();
    end
    finish_test("back-pressure");

    // Out-of-range address aliases onto a1 in the low index bits
    for (int i = 0; i < 2; i++) begin
      a1 = rand_addr();
      write_then_read(a1, 4'hf, 0);
      a2 = ADDR_W'(MEM_BYTES) + a1;
      write_then_read(a2, 4'hf, 0);
      send_ar(a1);
      wait_done();
    end
    finish_test("out of range");

    repeat (3) @(negedge clk);
    $display("%0d tests, %0d failed, %0d errors", test_num, failed_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("Timeout: the DUT stopped answering a handshake");
    $display("tests failed");
    $finish;
  end

endmodule

//--- vlog.f
logic/mem_pkg.sv
logic/latency_lfsr.sv
logic/sram_array.sv
logic/sram_rd_ctrl.sv
logic/sram_wr_ctrl.sv
logic/axi_sram.sv
tb/tb_axi_sram.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_sram -f vlog.f -o sim_axi_sram

./obj_dir/sim_axi_sram | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation OK"
exit 0
